/* src.f */
+incdir+test
design/riscv_pkg.sv
design/pipe_if.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/data_mem.sv
design/riscv_core.sv
test/tb_riscv_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -f src.f --top-module tb_riscv_core -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_riscv_core); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

/* test/tb_encode.svh */
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

// RV32I instruction formats, fields in spec order
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_pkg::OP_STORE};
endfunction

// Byte offset, bit 0 dropped
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OP_JAL};
endfunction

`endif

/* test/tb_riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;
  localparam int MAX_CYCLES  = 6 * 300;
  localparam int DRAIN_LIMIT = 300; // Per test after reset release

  logic                  clk;
  logic                  reset;
  logic                  prog_we;
  riscv_pkg::imem_addr_t prog_addr;
  riscv_pkg::inst_t      prog_data;
  riscv_pkg::xlen_t      csr;
  logic                  csr_we;

  logic [15:0]      lfsr_state;
  riscv_pkg::inst_t prog [$];
  riscv_pkg::xlen_t exp_q [$];
  string            cur_test;
  int               cycles;
  riscv_pkg::xlen_t expected_val;
  logic [7:0]       mem_model [4096]; // Byte image of data memory

  `include "tb_encode.svh"

  riscv_core riscv_core_i (
    .clk(clk), .reset(reset),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .csr(csr), .csr_we(csr_we)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      report_failure($sformatf("** Error: test %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      report_failure($sformatf("Timeout after %0d cycles in test %s", cycles, cur_test));
    end
  end

  // Registered outputs have settled by the falling edge
  always @(negedge clk) begin
    if (!reset && csr_we) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("Unexpected tohost write of %h in test %s", csr, cur_test));
      end else begin
        expected_val = exp_q.pop_front();
        check_value(cur_test, expected_val, csr);
      end
    end
  end

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input logic [2:0] f3, input int addr);
    logic [31:0] w;
    w = {mem_model[addr+3], mem_model[addr+2], mem_model[addr+1], mem_model[addr]};
    case (f3)
      3'd0:    return {{24{w[7]}}, w[7:0]};
      3'd4:    return {24'b0, w[7:0]};
      3'd1:    return {{16{w[15]}}, w[15:0]};
      3'd5:    return {16'b0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic model_store(input int addr, input logic [31:0] d, input int nbytes);
    for (int k = 0; k < nbytes; k++) begin
      mem_model[addr+k] = d[8*k +: 8];
    end
  endtask

  task automatic emit(input logic [31:0] inst);
    prog.push_back(inst);
  endtask

  // LUI+ADDI with the upper part rounded for the signed low half
  task automatic emit_li(input logic [4:0] rd, input logic [31:0] v);
    logic [19:0] hi;
    hi = v[31:12] + {19'b0, v[11]};
    emit(enc_u(hi, rd, riscv_pkg::OP_LUI));
    emit(enc_i(v[11:0], rd, 3'b000, rd, riscv_pkg::OP_IMM));
  endtask

  task automatic emit_tohost(input logic [4:0] rs, input logic [31:0] exp_v);
    emit(enc_i(riscv_pkg::CSR_TOHOST, rs, 3'b001, 5'd0, riscv_pkg::OP_SYSTEM));
    exp_q.push_back(exp_v);
  endtask

  task automatic emit_halt();
    emit(enc_j(21'd0, 5'd0)); // Jump to self
  endtask

  task automatic run_test(input string name);
    int waited;
    cur_test = name;
    reset    = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < prog.size(); i++) begin
      prog_we   = 1'b1;
      prog_addr = i[9:0];
      prog_data = prog[i];
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset  = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("Test %s ended with %0d tohost values never written",
                               name, exp_q.size()));
    end
    repeat (10) @(posedge clk); // Catch stray writes
    #1;
    prog.delete();
  endtask

  task automatic test_reg_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        alt;
    for (int i = 0; i < 10; i++) begin
      f3  = (i < 8) ? i[2:0] : ((i == 8) ? 3'd0 : 3'd5); // Then SUB and SRA
      alt = (i >= 8);
      a   = rand_bits(32);
      b   = rand_bits(32);
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, riscv_pkg::OP_REG));
      emit_tohost(5'd3, ref_alu(f3, alt, a, b));
    end
    emit_halt();
    run_test("reg_ops");
  endtask

  task automatic test_imm_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  shamt;
    for (int i = 0; i < 9; i++) begin
      case (i)
        0: f3 = 3'd0;
        1: f3 = 3'd2;
        2: f3 = 3'd3;
        3: f3 = 3'd4;
        4: f3 = 3'd6;
        5: f3 = 3'd7;
        6: f3 = 3'd1;
        default: f3 = 3'd5;
      endcase
      alt = (i == 8);
      a   = rand_bits(32);
      if (alt) begin
        a[31] = 1'b1; // SRAI on a negative value
      end
      if (f3 == 3'd1 || f3 == 3'd5) begin
        shamt = 5'(rand_bits(5));
        imm   = {alt ? 7'h20 : 7'h00, shamt};
        b     = {27'b0, shamt};
      end else begin
        imm = 12'(rand_bits(12));
        b   = {{20{imm[11]}}, imm};
      end
      emit_li(5'd1, a);
      emit(enc_i(imm, 5'd1, f3, 5'd3, riscv_pkg::OP_IMM));
      emit_tohost(5'd3, ref_alu(f3, alt, a, b));
    end
    emit_halt();
    run_test("imm_ops");
  endtask

  task automatic emit_load(input logic [2:0] f3, input int off);
    emit(enc_i(off[11:0], 5'd5, f3, 5'd7, riscv_pkg::OP_LOAD));
    emit_tohost(5'd7, load_ref(f3, 32'h100 + off)); // Used right after the load
  endtask

  task automatic test_mem_ops();
    logic [31:0] d;
    int          off;
    emit_li(5'd5, 32'h100);
    for (int w = 0; w < 2; w++) begin
      d   = rand_bits(32);
      off = w * 4;
      emit_li(5'd1, d);
      emit(enc_s(off[11:0], 5'd1, 5'd5, 3'b010));
      model_store(32'h100 + off, d, 4);
    end
    for (int k = 0; k < 4; k++) begin
      d   = rand_bits(32);
      off = 8 + k;
      emit_li(5'd1, d);
      emit(enc_s(off[11:0], 5'd1, 5'd5, 3'b000));
      model_store(32'h100 + off, d, 1);
    end
    for (int h = 0; h < 2; h++) begin
      d   = rand_bits(32);
      off = 12 + 2 * h;
      emit_li(5'd1, d);
      emit(enc_s(off[11:0], 5'd1, 5'd5, 3'b001));
      model_store(32'h100 + off, d, 2);
    end
    for (int k = 0; k < 4; k++) begin
      emit_load(3'd0, k);
      emit_load(3'd4, 8 + k);
    end
    emit_load(3'd1, 0);
    emit_load(3'd1, 2);
    emit_load(3'd1, 8);
    emit_load(3'd5, 12);
    emit_load(3'd5, 14);
    for (int w = 0; w < 4; w++) begin
      emit_load(3'd2, 4 * w);
    end
    emit_halt();
    run_test("mem_ops");
  endtask

  task automatic test_branches();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    for (int i = 0; i < 8; i++) begin
      case (i % 6)
        0: f3 = 3'd0;
        1: f3 = 3'd1;
        2: f3 = 3'd4;
        3: f3 = 3'd5;
        4: f3 = 3'd6;
        default: f3 = 3'd7;
      endcase
      a = rand_bits(32);
      b = rand_bits(32);
      if (rand_bits(1) == 32'd1) begin
        b = a;
      end
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, riscv_pkg::OP_IMM));
      emit(enc_b(13'd12, 5'd2, 5'd1, f3));
      emit(enc_i(12'd2, 5'd0, 3'b000, 5'd3, riscv_pkg::OP_IMM)); // Fall-through only
      emit(enc_i(12'd0, 5'd0, 3'b000, 5'd0, riscv_pkg::OP_IMM));
      emit_tohost(5'd3, ref_branch(f3, a, b) ? 32'd1 : 32'd2);
    end
    emit_halt();
    run_test("branches");
  endtask

  task automatic test_dep_chain();
    logic [31:0] a;
    logic [11:0] imm;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    logic [31:0] v5;
    logic [31:0] v8;
    a   = rand_bits(32);
    imm = 12'(rand_bits(12));
    v2  = ref_alu(3'd0, 1'b0, a, {{20{imm[11]}}, imm});
    v3  = ref_alu(3'd0, 1'b0, v2, a);
    v4  = ref_alu(3'd4, 1'b0, v3, v2);
    v5  = ref_alu(3'd0, 1'b1, v4, v3);
    v8  = ref_alu(3'd0, 1'b0, v5, v5);
    emit_li(5'd6, 32'h200);
    emit_li(5'd1, a);
    emit(enc_i(imm, 5'd1, 3'b000, 5'd2, riscv_pkg::OP_IMM));
    emit(enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, riscv_pkg::OP_REG));
    emit(enc_r(7'h00, 5'd2, 5'd3, 3'd4, 5'd4, riscv_pkg::OP_REG));
    emit(enc_r(7'h20, 5'd3, 5'd4, 3'd0, 5'd5, riscv_pkg::OP_REG));
    emit_tohost(5'd5, v5);
    emit(enc_s(12'd0, 5'd5, 5'd6, 3'b010));
    emit(enc_i(12'd0, 5'd6, 3'b010, 5'd7, riscv_pkg::OP_LOAD));
    emit(enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd8, riscv_pkg::OP_REG)); // Load-use
    emit(enc_r(7'h00, 5'd1, 5'd8, 3'd1, 5'd10, riscv_pkg::OP_REG));
    emit_tohost(5'd10, ref_alu(3'd1, 1'b0, v8, a));
    emit_tohost(5'd8, v8);
    emit(enc_i(12'd0, 5'd6, 3'b010, 5'd9, riscv_pkg::OP_LOAD));
    emit_tohost(5'd9, v5);
    emit_halt();
    run_test("dep_chain");
  endtask

  // Link and target values follow from the fixed word indices
  task automatic test_jumps();
    logic [4:0] uimm;
    uimm = 5'(rand_bits(5));
    emit(enc_j(21'd8, 5'd1));                                           // 0
    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd10, riscv_pkg::OP_IMM));       // 1
    emit_tohost(5'd1, 32'd4);                                           // 2
    emit_li(5'd2, 32'd33);                                              // 3, 4
    emit(enc_i(12'd0, 5'd2, 3'b000, 5'd3, riscv_pkg::OP_JALR));         // 5
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, riscv_pkg::OP_IMM));          // 6
    emit(enc_i(12'd8, 5'd0, 3'b000, 5'd3, riscv_pkg::OP_IMM));          // 7
    emit(enc_i(riscv_pkg::CSR_TOHOST, 5'd3, 3'b001, 5'd4, riscv_pkg::OP_SYSTEM));
    exp_q.push_back(32'd24);                                            // 8
    emit(enc_i(riscv_pkg::CSR_TOHOST, uimm, 3'b101, 5'd5, riscv_pkg::OP_SYSTEM));
    exp_q.push_back({27'b0, uimm});                                     // 9
    emit_tohost(5'd5, 32'd24);                                          // 10
    emit_tohost(5'd4, 32'd4);                                           // 11
    emit(enc_j(21'd8, 5'd6));                                           // 12
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, riscv_pkg::OP_IMM));          // 13
    emit(enc_u(20'd0, 5'd7, riscv_pkg::OP_AUIPC));                      // 14
    emit_tohost(5'd7, 32'd56);                                          // 15
    emit_tohost(5'd6, 32'd52);                                          // 16
    emit_halt();
    run_test("jumps");
  endtask

  initial begin
    reset      = 1'b1;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    cycles     = 0;
    cur_test   = "init";
    lfsr_state = 16'd46664;
    test_reg_ops();
    test_imm_ops();
    test_mem_ops();
    test_branches();
    test_dep_chain();
    test_jumps();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* design/riscv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  prog_we,
  input  riscv_pkg::imem_addr_t prog_addr,
  input  riscv_pkg::inst_t      prog_data,
  output riscv_pkg::xlen_t      csr,
  output logic                  csr_we
);
  riscv_pkg::inst_t      inst;
  riscv_pkg::pc_t        inst_pc;
  logic                  inst_valid;
  logic                  redirect;
  riscv_pkg::pc_t        redirect_pc;
  riscv_pkg::reg_addr_t  rs1_addr;
  riscv_pkg::reg_addr_t  rs2_addr;
  riscv_pkg::xlen_t      rs1_data;
  riscv_pkg::xlen_t      rs2_data;
  logic                  wb_we;
  riscv_pkg::reg_addr_t  wb_rd;
  riscv_pkg::xlen_t      wb_data;
  riscv_pkg::dmem_addr_t mem_addr;
  riscv_pkg::xlen_t      mem_wdata;
  riscv_pkg::xlen_t      mem_rdata;
  logic [3:0]            mem_be;
  logic                  mem_re;
  logic [2:0]            mem_funct3;
  logic [1:0]            mem_byte_off;

  pipe_if dx ();

  fetch_stage fetch (
    .clk(clk), .reset(reset),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .redirect(redirect), .redirect_pc(redirect_pc), .flush(dx.flush),
    .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid)
  );

  decode_stage decode (
    .clk(clk), .reset(reset),
    .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .dx(dx)
  );

  reg_file regs (
    .clk(clk), .reset(reset),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  execute_stage execute (
    .clk(clk), .reset(reset), .dx(dx),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_be(mem_be), .mem_re(mem_re),
    .mem_funct3(mem_funct3), .mem_byte_off(mem_byte_off), .mem_rdata(mem_rdata),
    .csr(csr), .csr_we(csr_we)
  );

  data_mem dmem (
    .clk(clk), .addr(mem_addr), .wdata(mem_wdata), .be(mem_be), .re(mem_re),
    .funct3(mem_funct3), .byte_off(mem_byte_off), .rdata(mem_rdata)
  );

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
  input  logic                  clk,
  input  riscv_pkg::dmem_addr_t addr,
  input  riscv_pkg::xlen_t      wdata,
  input  logic [3:0]            be,
  input  logic                  re,
  input  logic [2:0]            funct3,
  input  logic [1:0]            byte_off,
  output riscv_pkg::xlen_t      rdata
);
  riscv_pkg::xlen_t mem [riscv_pkg::DMEM_DEPTH];
  riscv_pkg::xlen_t word_q;
  riscv_pkg::xlen_t lane;
  logic [2:0]       funct3_q;
  logic [1:0]       off_q;

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    if (re) begin
      word_q   <= mem[addr];
      funct3_q <= funct3; // Kept for extraction next cycle
      off_q    <= byte_off;
    end
  end

  assign lane = word_q >> {off_q, 3'b000}; // Addressed byte down to bit 0

  always_comb begin
    case (funct3_q)
      riscv_pkg::F3_LB:  rdata = {{24{lane[7]}}, lane[7:0]};
      riscv_pkg::F3_LBU: rdata = {24'b0, lane[7:0]};
      riscv_pkg::F3_LH:  rdata = {{16{lane[15]}}, lane[15:0]};
      riscv_pkg::F3_LHU: rdata = {16'b0, lane[15:0]};
      default:           rdata = word_q;
    endcase
  end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                  clk,
  input  logic                  reset,
  pipe_if.execute_mp            dx,
  output logic                  redirect,
  output riscv_pkg::pc_t        redirect_pc,
  output logic                  wb_we,
  output riscv_pkg::reg_addr_t  wb_rd,
  output riscv_pkg::xlen_t      wb_data,
  output riscv_pkg::dmem_addr_t mem_addr,
  output riscv_pkg::xlen_t      mem_wdata,
  output logic [3:0]            mem_be,
  output logic                  mem_re,
  output logic [2:0]            mem_funct3,
  output logic [1:0]            mem_byte_off,
  input  riscv_pkg::xlen_t      mem_rdata,
  output riscv_pkg::xlen_t      csr,
  output logic                  csr_we
);
  riscv_pkg::xlen_t   rs1_val;
  riscv_pkg::xlen_t   rs2_val;
  riscv_pkg::xlen_t   op_a;
  riscv_pkg::xlen_t   op_b;
  riscv_pkg::xlen_t   alu_y;
  logic               cond;
  logic               wb_valid_q;
  riscv_pkg::wb_sel_e wb_sel_q;
  riscv_pkg::xlen_t   result_q;
  riscv_pkg::pc_t     pc4_q;

  // Writeback bypass, load data included
  assign rs1_val = (wb_we && wb_rd == dx.rs1) ? wb_data : dx.rs1_val;
  assign rs2_val = (wb_we && wb_rd == dx.rs2) ? wb_data : dx.rs2_val;
  assign op_a    = dx.a_pc ? dx.pc : rs1_val;
  assign op_b    = dx.b_imm ? dx.imm : rs2_val;

  always_comb begin
    case (dx.alu_op)
      riscv_pkg::ALU_ADD:  alu_y = op_a + op_b;
      riscv_pkg::ALU_SUB:  alu_y = op_a - op_b;
      riscv_pkg::ALU_SLL:  alu_y = op_a << op_b[4:0];
      riscv_pkg::ALU_SLT:  alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      riscv_pkg::ALU_SLTU: alu_y = {31'b0, op_a < op_b};
      riscv_pkg::ALU_XOR:  alu_y = op_a ^ op_b;
      riscv_pkg::ALU_SRL:  alu_y = op_a >> op_b[4:0];
      riscv_pkg::ALU_SRA:  alu_y = $signed(op_a) >>> op_b[4:0];
      riscv_pkg::ALU_OR:   alu_y = op_a | op_b;
      riscv_pkg::ALU_AND:  alu_y = op_a & op_b;
      default:             alu_y = op_b;
    endcase
  end

  always_comb begin
    case (dx.funct3)
      riscv_pkg::F3_BEQ:  cond = rs1_val == rs2_val;
      riscv_pkg::F3_BNE:  cond = rs1_val != rs2_val;
      riscv_pkg::F3_BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
      riscv_pkg::F3_BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
      riscv_pkg::F3_BLTU: cond = rs1_val < rs2_val;
      riscv_pkg::F3_BGEU: cond = rs1_val >= rs2_val;
      default:            cond = 1'b0;
    endcase
  end

  assign redirect    = dx.valid && (dx.jump || (dx.branch && cond));
  assign redirect_pc = dx.jalr ? {alu_y[31:1], 1'b0} : dx.pc + dx.imm;
  assign dx.flush    = redirect; // Kills the fetch and decode slots

  // Lane replication, byte enables pick the lane
  always_comb begin
    case (dx.funct3)
      riscv_pkg::F3_SB: begin
        mem_wdata = {4{rs2_val[7:0]}};
        mem_be    = 4'b0001 << alu_y[1:0];
      end
      riscv_pkg::F3_SH: begin
        mem_wdata = {2{rs2_val[15:0]}};
        mem_be    = 4'b0011 << {alu_y[1], 1'b0};
      end
      default: begin
        mem_wdata = rs2_val;
        mem_be    = 4'b1111;
      end
    endcase
    if (!(dx.valid && dx.store)) begin
      mem_be = 4'b0000;
    end
  end

  assign mem_addr     = alu_y[11:2];
  assign mem_byte_off = alu_y[1:0];
  assign mem_re       = dx.valid && dx.load;
  assign mem_funct3   = dx.funct3;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid_q <= 1'b0;
      csr_we     <= 1'b0;
      csr        <= '0;
    end else begin
      wb_valid_q <= dx.valid;
      csr_we     <= dx.valid && dx.csr_we;
      if (dx.valid && dx.csr_we) begin
        csr <= dx.csr_imm ? {27'b0, dx.rs1} : rs1_val; // uimm sits in the rs1 field
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_sel_q <= dx.wb_sel;
    wb_rd    <= dx.rd;
    result_q <= dx.csr_we ? csr : alu_y; // CSRRW returns the old tohost
    pc4_q    <= dx.pc + 32'd4;
  end

  assign wb_we = wb_valid_q && wb_sel_q != riscv_pkg::WB_NONE && wb_rd != '0;

  always_comb begin
    case (wb_sel_q)
      riscv_pkg::WB_MEM: wb_data = mem_rdata;
      riscv_pkg::WB_PC4: wb_data = pc4_q;
      default:           wb_data = result_q;
    endcase
  end

  // Halfword and word accesses stay naturally aligned
  assert property (@(posedge clk) disable iff (reset)
    dx.valid && (dx.load || dx.store) |->
      !(dx.funct3[1:0] == 2'b01 && alu_y[0]) &&
      !(dx.funct3[1:0] == 2'b10 && alu_y[1:0] != 2'b00));

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  riscv_pkg::inst_t     inst,
  input  riscv_pkg::pc_t       inst_pc,
  input  logic                 inst_valid,
  output riscv_pkg::reg_addr_t rs1_addr,
  output riscv_pkg::reg_addr_t rs2_addr,
  input  riscv_pkg::xlen_t     rs1_data,
  input  riscv_pkg::xlen_t     rs2_data,
  pipe_if.decode_mp            dx
);
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  riscv_pkg::xlen_t   imm_i;
  riscv_pkg::xlen_t   imm_s;
  riscv_pkg::xlen_t   imm_b;
  riscv_pkg::xlen_t   imm_u;
  riscv_pkg::xlen_t   imm_j;
  riscv_pkg::xlen_t   imm;
  riscv_pkg::alu_op_e alu_op;
  riscv_pkg::wb_sel_e wb_sel;
  logic               a_pc;
  logic               b_imm;
  logic               branch;
  logic               jump;
  logic               jalr;
  logic               store;
  logic               load;
  logic               csr_we;
  logic               csr_imm;

  // Bit 30 selects SUB only for register ops and SRA for both
  function automatic riscv_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                                    input logic is_reg);
    case (f3)
      3'b000:  return (alt && is_reg) ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
      3'b001:  return riscv_pkg::ALU_SLL;
      3'b010:  return riscv_pkg::ALU_SLT;
      3'b011:  return riscv_pkg::ALU_SLTU;
      3'b100:  return riscv_pkg::ALU_XOR;
      3'b101:  return alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110:  return riscv_pkg::ALU_OR;
      default: return riscv_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm     = imm_i;
    alu_op  = riscv_pkg::ALU_ADD; // Address and link math
    a_pc    = 1'b0;
    b_imm   = 1'b1;
    wb_sel  = riscv_pkg::WB_NONE;
    {branch, jump, jalr, store, load, csr_we, csr_imm} = '0;
    case (opcode)
      riscv_pkg::OP_LUI: begin
        imm    = imm_u;
        alu_op = riscv_pkg::ALU_PASS_B;
        wb_sel = riscv_pkg::WB_ALU;
      end
      riscv_pkg::OP_AUIPC: begin
        imm    = imm_u;
        a_pc   = 1'b1;
        wb_sel = riscv_pkg::WB_ALU;
      end
      riscv_pkg::OP_JAL: begin
        imm    = imm_j;
        jump   = 1'b1;
        wb_sel = riscv_pkg::WB_PC4;
      end
      riscv_pkg::OP_JALR: begin
        jump   = 1'b1;
        jalr   = 1'b1;
        wb_sel = riscv_pkg::WB_PC4;
      end
      riscv_pkg::OP_BRANCH: begin
        imm    = imm_b;
        branch = 1'b1;
      end
      riscv_pkg::OP_LOAD: begin
        load   = 1'b1;
        wb_sel = riscv_pkg::WB_MEM;
      end
      riscv_pkg::OP_STORE: begin
        imm   = imm_s;
        store = 1'b1;
      end
      riscv_pkg::OP_IMM: begin
        alu_op = alu_decode(funct3, inst[30], 1'b0);
        wb_sel = riscv_pkg::WB_ALU;
      end
      riscv_pkg::OP_REG: begin
        alu_op = alu_decode(funct3, inst[30], 1'b1);
        b_imm  = 1'b0;
        wb_sel = riscv_pkg::WB_ALU;
      end
      riscv_pkg::OP_SYSTEM: begin
        // Only tohost exists so other CSR numbers fall through as no-ops
        if ((funct3 == riscv_pkg::F3_CSRRW || funct3 == riscv_pkg::F3_CSRRWI) &&
            inst[31:20] == riscv_pkg::CSR_TOHOST) begin
          csr_we  = 1'b1;
          csr_imm = (funct3 == riscv_pkg::F3_CSRRWI);
          wb_sel  = riscv_pkg::WB_ALU;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= inst_valid && !dx.flush;
    end
  end

  always_ff @(posedge clk) begin
    dx.pc      <= inst_pc;
    dx.rs1     <= rs1_addr;
    dx.rs2     <= rs2_addr;
    dx.rs1_val <= rs1_data;
    dx.rs2_val <= rs2_data;
    dx.imm     <= imm;
    dx.rd      <= inst[11:7];
    dx.alu_op  <= alu_op;
    dx.a_pc    <= a_pc;
    dx.b_imm   <= b_imm;
    dx.wb_sel  <= wb_sel;
    dx.branch  <= branch;
    dx.jump    <= jump;
    dx.jalr    <= jalr;
    dx.store   <= store;
    dx.load    <= load;
    dx.funct3  <= funct3;
    dx.csr_we  <= csr_we;
    dx.csr_imm <= csr_imm;
  end

  // Branch and jump targets land on word boundaries
  assert property (@(posedge clk) disable iff (reset) inst_valid |-> inst_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  riscv_pkg::reg_addr_t rs1_addr,
  input  riscv_pkg::reg_addr_t rs2_addr,
  output riscv_pkg::xlen_t     rs1_data,
  output riscv_pkg::xlen_t     rs2_data,
  input  logic                 wb_we,
  input  riscv_pkg::reg_addr_t wb_rd,
  input  riscv_pkg::xlen_t     wb_data
);
  riscv_pkg::xlen_t regs [32]; // Entry 0 never written

  // Same-cycle write shows up on the read port
  function automatic riscv_pkg::xlen_t read_port(input riscv_pkg::reg_addr_t a);
    if (a == '0) begin
      return '0;
    end
    if (wb_we && wb_rd == a) begin
      return wb_data;
    end
    return regs[a];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  prog_we,
  input  riscv_pkg::imem_addr_t prog_addr,
  input  riscv_pkg::inst_t      prog_data,
  input  logic                  redirect,
  input  riscv_pkg::pc_t        redirect_pc,
  input  logic                  flush,
  output riscv_pkg::inst_t      inst,
  output riscv_pkg::pc_t        inst_pc,
  output logic                  inst_valid
);
  riscv_pkg::inst_t      imem [riscv_pkg::IMEM_DEPTH];
  riscv_pkg::pc_t        pc_q;
  riscv_pkg::imem_addr_t rd_addr;

  assign rd_addr = pc_q[11:2]; // Word index

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= riscv_pkg::RESET_PC;
    end else if (redirect) begin
      pc_q <= redirect_pc;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Program port is only used while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
    inst    <= imem[rd_addr];
    inst_pc <= pc_q;
  end

  // Word fetched in the redirect cycle is from the wrong path
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= 1'b1;
    end
  end

  // Loading while running would race the fetch path
  assert property (@(posedge clk) prog_we |-> reset);

endmodule

`default_nettype wire

/* design/pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One decoded instruction, decode to execute
interface pipe_if;
  logic                 valid;
  riscv_pkg::pc_t       pc;
  riscv_pkg::reg_addr_t rs1;
  riscv_pkg::reg_addr_t rs2;
  riscv_pkg::xlen_t     rs1_val;
  riscv_pkg::xlen_t     rs2_val;
  riscv_pkg::xlen_t     imm;
  riscv_pkg::reg_addr_t rd;
  riscv_pkg::alu_op_e   alu_op;
  logic                 a_pc;   // A operand is pc
  logic                 b_imm;  // B operand is imm
  riscv_pkg::wb_sel_e   wb_sel;
  logic                 branch;
  logic                 jump;
  logic                 jalr;
  logic                 store;
  logic                 load;
  logic [2:0]           funct3;
  logic                 csr_we;
  logic                 csr_imm;
  logic                 flush;  // Taken branch or jump in execute

  modport decode_mp (output valid, pc, rs1, rs2, rs1_val, rs2_val, imm, rd, alu_op, a_pc,
                     b_imm, wb_sel, branch, jump, jalr, store, load, funct3, csr_we,
                     csr_imm, input flush);
  modport execute_mp (input valid, pc, rs1, rs2, rs1_val, rs2_val, imm, rd, alu_op, a_pc,
                      b_imm, wb_sel, branch, jump, jalr, store, load, funct3, csr_we,
                      csr_imm, output flush);
endinterface

`default_nettype wire

/* design/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [9:0]  imem_addr_t; // 1K instruction words
  typedef logic [9:0]  dmem_addr_t; // 4 KB of data

  localparam int          IMEM_DEPTH = 1024;
  localparam int          DMEM_DEPTH = 1024;
  localparam pc_t         RESET_PC   = 32'h0000_0000;
  localparam logic [11:0] CSR_TOHOST = 12'h51e;

  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load and store widths, word access is the fallback
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;

  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRWI = 3'b101;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_PASS_B // LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_MEM, WB_PC4, WB_NONE
  } wb_sel_e;

endpackage

`default_nettype wire
